// File: list.f
verilog/axi_pkg.sv
verilog/read_master_pkg.sv
verilog/burst_plan_if.sv
verilog/burst_counter.sv
verilog/xfer_setup.sv
verilog/ar_issuer.sv
verilog/r_tracker.sv
verilog/read_data_fifo.sv
verilog/read_master_top.sv
verification/read_master_assert.sv
verification/tb_read_master.sv

// File: Bender.yml
package:
  name: read_master

sources:
  - files:
      - verilog/axi_pkg.sv
      - verilog/read_master_pkg.sv
      - verilog/burst_plan_if.sv
      - verilog/burst_counter.sv
      - verilog/xfer_setup.sv
      - verilog/ar_issuer.sv
      - verilog/r_tracker.sv
      - verilog/read_data_fifo.sv
      - verilog/read_master_top.sv
  - target: test
    files:
      - verification/read_master_assert.sv
      - verification/tb_read_master.sv

// File: verification/tb_read_master.sv
`timescale 1ns/1ps
`default_nettype none

module tb_read_master;

  // One full burst is 1 KiB on a 32-bit bus
  localparam int beats_per_burst = 256;
  localparam int timeout_cycles  = 20000;

  logic        aclk = 1'b0;
  logic        areset;
  logic        ctrl_start;
  logic        ctrl_done;
  logic [31:0] ctrl_addr_offset;
  logic [31:0] ctrl_xfer_size_in_bytes;
  logic        m_axi_arvalid;
  logic        m_axi_arready = 1'b0;
  logic [31:0] m_axi_araddr;
  logic [7:0]  m_axi_arlen;
  logic        m_axi_rvalid  = 1'b0;
  logic        m_axi_rready;
  logic [31:0] m_axi_rdata   = '0;
  logic        m_axi_rlast   = 1'b0;
  logic        m_axis_tvalid;
  logic        m_axis_tready = 1'b0;
  logic [31:0] m_axis_tdata;
  logic        m_axis_tlast;

  integer seed = 99;

  // Slave model state
  logic [31:0] ar_addr_q [$];
  int          ar_len_q [$];
  logic        r_active = 1'b0;
  logic [31:0] r_addr;
  int          r_beat;
  int          r_len;

  // Received stream beats, handed to the compare process
  logic [31:0] rx_data_q [$];
  logic        rx_last_q [$];

  // Per-transfer bookkeeping
  string       test_name = "none";
  logic [31:0] cur_offset = '0;
  int          cur_total = 0;
  int          rx_idx = 0;
  int          ar_count = 0;
  int          r_beats = 0;
  int          pop_count = 0;
  int          done_count = 0;
  logic        done_prev = 1'b0;
  logic        hold_tready = 1'b0;

  int          error_count = 0;
  int          test_err_start = 0;
  int          test_count = 0;
  int          failed_tests = 0;

  read_master_top #(
    .addr_width      (32),
    .data_width      (32),
    .max_outstanding (4)
  ) i_dut (
    .aclk                    (aclk),
    .areset                  (areset),
    .ctrl_start              (ctrl_start),
    .ctrl_done               (ctrl_done),
    .ctrl_addr_offset        (ctrl_addr_offset),
    .ctrl_xfer_size_in_bytes (ctrl_xfer_size_in_bytes),
    .m_axi_arvalid           (m_axi_arvalid),
    .m_axi_arready           (m_axi_arready),
    .m_axi_araddr            (m_axi_araddr),
    .m_axi_arlen             (m_axi_arlen),
    .m_axi_rvalid            (m_axi_rvalid),
    .m_axi_rready            (m_axi_rready),
    .m_axi_rdata             (m_axi_rdata),
    .m_axi_rlast             (m_axi_rlast),
    .m_axis_tvalid           (m_axis_tvalid),
    .m_axis_tready           (m_axis_tready),
    .m_axis_tdata            (m_axis_tdata),
    .m_axis_tlast            (m_axis_tlast)
  );

  initial begin
    forever #2 aclk = ~aclk;
  end

  // Data of stream beat idx: aligned base plus four bytes per beat
  function automatic logic [31:0] expected_beat(input logic [31:0] offset, input int idx);
    return {offset[31:10], 10'd0} + 32'(idx * 4);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Slave memory model and stream sink, all driven on the falling edge
  //////////////////////////////////////////////////////////////////////

  always @(negedge aclk) begin : bus_model
    // Done pulse, one cycle wide and only after every R beat
    if (ctrl_done) begin
      done_count++;
      if (done_prev) begin
        $display("[ERROR] %s: ctrl_done stayed high for more than one cycle", test_name);
        error_count++;
      end
      if (r_beats != cur_total) begin
        $display("[ERROR] %s R beats before done: expected %0d, actual %0d",
                 test_name, cur_total, r_beats);
        error_count++;
      end
    end
    done_prev = ctrl_done;

    // R channel, one burst at a time in request order
    m_axi_rvalid = 1'b0;
    m_axi_rlast  = 1'b0;
    if (!r_active && ar_addr_q.size() > 0) begin
      r_addr   = ar_addr_q.pop_front();
      r_len    = ar_len_q.pop_front();
      r_beat   = 0;
      r_active = 1'b1;
    end
    if (r_active && (($random(seed) & 3) != 0)) begin
      // Master must take every beat it is offered
      if (m_axi_rready !== 1'b1) begin
        $display("[ERROR] %s rready: expected 1, actual %b", test_name, m_axi_rready);
        error_count++;
      end
      m_axi_rvalid = 1'b1;
      // Beat data is its own byte address
      m_axi_rdata  = r_addr + 32'(r_beat * 4);
      m_axi_rlast  = (r_beat == r_len);
      r_beats++;
      if (r_beat == r_len) begin
        r_active = 1'b0;
      end else begin
        r_beat++;
      end
    end

    // AR channel with random ready, handshake lands on the next rising edge
    m_axi_arready = $random(seed) & 1;
    if (m_axi_arvalid && m_axi_arready) begin
      ar_addr_q.push_back(m_axi_araddr);
      ar_len_q.push_back(int'(m_axi_arlen));
      ar_count++;
    end

    // Stream sink
    m_axis_tready = hold_tready ? 1'b0 : (($random(seed) & 3) != 0);
    if (m_axis_tvalid && m_axis_tready) begin
      rx_data_q.push_back(m_axis_tdata);
      rx_last_q.push_back(m_axis_tlast);
      pop_count++;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Compare process
  //////////////////////////////////////////////////////////////////////

  always @(posedge aclk) begin : compare_stream
    logic [31:0] got_data;
    logic        got_last;
    logic [31:0] exp_data;
    logic        exp_last;
    while (rx_data_q.size() > 0) begin
      got_data = rx_data_q.pop_front();
      got_last = rx_last_q.pop_front();
      exp_data = expected_beat(cur_offset, rx_idx);
      // Last on every full burst and on the final beat
      exp_last = ((rx_idx % beats_per_burst) == beats_per_burst - 1) ||
                 (rx_idx == cur_total - 1);
      if (rx_idx >= cur_total) begin
        $display("[ERROR] %s: stream beat %0d is beyond the transfer length",
                 test_name, rx_idx);
        error_count++;
      end
      if (got_data !== exp_data) begin
        $display("[ERROR] %s beat %0d tdata: expected %h, actual %h",
                 test_name, rx_idx, exp_data, got_data);
        error_count++;
      end
      if (got_last !== exp_last) begin
        $display("[ERROR] %s beat %0d tlast: expected %b, actual %b",
                 test_name, rx_idx, exp_last, got_last);
        error_count++;
      end
      rx_idx++;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Test tasks
  //////////////////////////////////////////////////////////////////////

  task automatic begin_test(input string name);
    test_name      = name;
    test_err_start = error_count;
  endtask

  task automatic end_test;
    test_count++;
    if (error_count == test_err_start) begin
      $display("[PASS] %s", test_name);
    end else begin
      $display("[FAIL] %s: %0d errors", test_name, error_count - test_err_start);
      failed_tests++;
    end
  endtask

  // Bookkeeping changes while the bus is idle, request on the falling edge
  task automatic start_transfer(input logic [31:0] offset, input int size);
    @(posedge aclk);
    cur_offset = offset;
    cur_total  = (size + 3) / 4;
    rx_idx     = 0;
    ar_count   = 0;
    r_beats    = 0;
    pop_count  = 0;
    done_count = 0;
    @(negedge aclk);
    ctrl_start              = 1'b1;
    ctrl_addr_offset        = offset;
    ctrl_xfer_size_in_bytes = size;
    @(negedge aclk);
    ctrl_start = 1'b0;
  endtask

  task automatic finish_transfer;
    int cyc;
    cyc = 0;
    while (done_count == 0 && cyc < timeout_cycles) begin
      @(posedge aclk);
      cyc++;
    end
    if (done_count == 0) begin
      $display("[TIMEOUT] %s: ctrl_done never pulsed", test_name);
      error_count++;
    end
    cyc = 0;
    while (pop_count < cur_total && cyc < timeout_cycles) begin
      @(posedge aclk);
      cyc++;
    end
    if (pop_count < cur_total) begin
      $display("[TIMEOUT] %s: stream delivered only %0d of %0d beats",
               test_name, pop_count, cur_total);
      error_count++;
    end
    // Quiet window so a second done or a stray beat shows up
    for (cyc = 0; cyc < 32; cyc++) begin
      @(posedge aclk);
    end
    if (done_count != 1) begin
      $display("[ERROR] %s done pulses: expected 1, actual %0d", test_name, done_count);
      error_count++;
    end
    if (pop_count != cur_total) begin
      $display("[ERROR] %s stream beats: expected %0d, actual %0d",
               test_name, cur_total, pop_count);
      error_count++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin : main
    int cyc;
    areset                  = 1'b1;
    ctrl_start              = 1'b0;
    ctrl_addr_offset        = '0;
    ctrl_xfer_size_in_bytes = '0;
    for (cyc = 0; cyc < 8; cyc++) begin
      @(negedge aclk);
    end
    areset = 1'b0;
    @(negedge aclk);

    begin_test("reset_state");
    if (m_axi_arvalid !== 1'b0) begin
      $display("[ERROR] %s arvalid: expected 0, actual %b", test_name, m_axi_arvalid);
      error_count++;
    end
    if (ctrl_done !== 1'b0) begin
      $display("[ERROR] %s ctrl_done: expected 0, actual %b", test_name, ctrl_done);
      error_count++;
    end
    if (m_axis_tvalid !== 1'b0) begin
      $display("[ERROR] %s tvalid: expected 0, actual %b", test_name, m_axis_tvalid);
      error_count++;
    end
    end_test();

    // 100 bytes is exactly 25 beats
    begin_test("rounding");
    start_transfer(32'h0000_2000, 100);
    finish_transfer();
    end_test();

    // 750 beats in bursts of 256, 256 and 238
    begin_test("multi_burst");
    start_transfer(32'h0001_0000, 3000);
    finish_transfer();
    end_test();

    // Offset 0x30A5C aligns down to 0x30800
    begin_test("alignment");
    start_transfer(32'h0003_0A5C, 200);
    finish_transfer();
    end_test();

    // Six bursts, stream held off so only four may be requested
    begin_test("stalled_stream");
    @(posedge aclk);
    hold_tready = 1'b1;
    start_transfer(32'h0004_0000, 6000);
    cyc = 0;
    while (ar_count < 4 && cyc < timeout_cycles) begin
      @(posedge aclk);
      cyc++;
    end
    if (ar_count < 4) begin
      $display("[TIMEOUT] %s: only %0d AR requests arrived", test_name, ar_count);
      error_count++;
    end
    // All four granted bursts land in the FIFO while the stream is stalled
    cyc = 0;
    while (r_beats < 4 * beats_per_burst && cyc < timeout_cycles) begin
      @(posedge aclk);
      cyc++;
    end
    if (r_beats < 4 * beats_per_burst) begin
      $display("[TIMEOUT] %s: only %0d R beats arrived while stalled", test_name, r_beats);
      error_count++;
    end
    if (ar_count > 4) begin
      $display("[ERROR] %s AR handshakes before any pop: expected 4, actual %0d",
               test_name, ar_count);
      error_count++;
    end
    @(posedge aclk);
    hold_tready = 1'b0;
    finish_transfer();
    end_test();

    // Odd size with a one-beat last burst, then a short follow-up
    begin_test("done_repeat");
    start_transfer(32'h0005_0104, 4097);
    finish_transfer();
    start_transfer(32'h0000_6000, 64);
    finish_transfer();
    end_test();

    $display("Summary: %0d tests, %0d failed, %0d errors", test_count, failed_tests, error_count);
    if (error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule : tb_read_master

`default_nettype wire

// File: verification/read_master_assert.sv
`timescale 1ns/1ps
`default_nettype none

module read_master_assert #(
  parameter int addr_width      = 32,
  parameter int max_outstanding = 4,
  parameter int vac_width       = $clog2(max_outstanding + 1)
) (
  input wire logic                  aclk,
  input wire logic                  areset,
  input wire logic                  ar_idle,
  input wire logic                  arvalid,
  input wire logic                  arready,
  input wire logic [addr_width-1:0] araddr,
  input wire logic [7:0]            arlen,
  input wire logic [vac_width-1:0]  vacancy_count
);

  //////////////////////////////////////////////////////////////////////
  // AR channel rules
  //////////////////////////////////////////////////////////////////////

  // Pending request holds address and length until accepted
  a_ar_stable : assert property (
    @(posedge aclk) disable iff (areset)
    arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen)
  ) else $error("AR request changed while arready was low");

  // No request while the issuer is idle or just out of reset
  a_ar_idle : assert property (
    @(posedge aclk) disable iff (areset)
    ar_idle |-> !arvalid
  ) else $error("arvalid high while the issuer is idle");

  // Vacancy never grows past the configured limit
  a_vacancy : assert property (
    @(posedge aclk) disable iff (areset)
    vacancy_count <= max_outstanding
  ) else $error("vacancy count above max_outstanding");

endmodule : read_master_assert

bind ar_issuer read_master_assert #(
  .addr_width      (addr_width),
  .max_outstanding (max_outstanding)
) i_ar_assert (
  .aclk          (aclk),
  .areset        (areset),
  .ar_idle       (ar_idle),
  .arvalid       (m_axi_arvalid),
  .arready       (m_axi_arready),
  .araddr        (m_axi_araddr),
  .arlen         (m_axi_arlen),
  .vacancy_count (vacancy_count)
);

`default_nettype wire

// File: verilog/read_master_top.sv
`timescale 1ns/1ps
`default_nettype none

module read_master_top #(
  parameter int addr_width      = read_master_pkg::DEFAULT_ADDR_WIDTH,
  parameter int data_width      = read_master_pkg::DEFAULT_DATA_WIDTH,
  parameter int xfer_size_width = addr_width,
  parameter int max_outstanding = read_master_pkg::DEFAULT_MAX_OUTSTANDING
) (
  input  logic                       aclk,
  input  logic                       areset,
  // Control, sampled on ctrl_start
  input  logic                       ctrl_start,
  output logic                       ctrl_done,
  input  logic [addr_width-1:0]      ctrl_addr_offset,
  input  logic [xfer_size_width-1:0] ctrl_xfer_size_in_bytes,
  // AXI4 read address channel
  output logic                       m_axi_arvalid,
  input  logic                       m_axi_arready,
  output logic [addr_width-1:0]      m_axi_araddr,
  output axi_pkg::axi_len_t          m_axi_arlen,
  // AXI4 read data channel
  input  logic                       m_axi_rvalid,
  output logic                       m_axi_rready,
  input  logic [data_width-1:0]      m_axi_rdata,
  input  logic                       m_axi_rlast,
  // AXI4-Stream output
  output logic                       m_axis_tvalid,
  input  logic                       m_axis_tready,
  output logic [data_width-1:0]      m_axis_tdata,
  output logic                       m_axis_tlast
);
  import read_master_pkg::*;

  localparam int burst_len = burst_beats(data_width);
  // Bits left for the burst count once beat and burst offsets are dropped
  localparam int cnt_width = xfer_size_width - $clog2(data_width / 8) - $clog2(burst_len);
  // Room for every outstanding burst, power of two
  localparam int fifo_depth = 2 ** $clog2(burst_len * max_outstanding);

  logic burst_retired;

  // FIFO always has room for what was requested
  assign m_axi_rready = 1'b1;

  burst_plan_if #(
    .addr_width (addr_width),
    .cnt_width  (cnt_width)
  ) plan ();

  xfer_setup #(
    .addr_width      (addr_width),
    .data_width      (data_width),
    .xfer_size_width (xfer_size_width),
    .cnt_width       (cnt_width)
  ) i_setup (
    .aclk                    (aclk),
    .areset                  (areset),
    .ctrl_start              (ctrl_start),
    .ctrl_addr_offset        (ctrl_addr_offset),
    .ctrl_xfer_size_in_bytes (ctrl_xfer_size_in_bytes),
    .plan                    (plan.setup)
  );

  ar_issuer #(
    .addr_width      (addr_width),
    .data_width      (data_width),
    .cnt_width       (cnt_width),
    .max_outstanding (max_outstanding)
  ) i_ar_issuer (
    .aclk          (aclk),
    .areset        (areset),
    .plan          (plan.issuer),
    .burst_retired (burst_retired),
    .m_axi_arvalid (m_axi_arvalid),
    .m_axi_arready (m_axi_arready),
    .m_axi_araddr  (m_axi_araddr),
    .m_axi_arlen   (m_axi_arlen)
  );

  r_tracker #(
    .cnt_width (cnt_width)
  ) i_r_tracker (
    .aclk         (aclk),
    .areset       (areset),
    .plan         (plan.tracker),
    .m_axi_rvalid (m_axi_rvalid),
    .m_axi_rlast  (m_axi_rlast),
    .ctrl_done    (ctrl_done)
  );

  read_data_fifo #(
    .data_width (data_width),
    .depth      (fifo_depth)
  ) i_data_fifo (
    .aclk          (aclk),
    .areset        (areset),
    .wr_en         (m_axi_rvalid),
    .wr_data       (m_axi_rdata),
    .wr_last       (m_axi_rlast),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tlast  (m_axis_tlast),
    .burst_retired (burst_retired)
  );

endmodule : read_master_top

`default_nettype wire

// File: verilog/read_data_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module read_data_fifo #(
  parameter int data_width = read_master_pkg::DEFAULT_DATA_WIDTH,
  parameter int depth      = 4096
) (
  input  logic                  aclk,
  input  logic                  areset,
  input  logic                  wr_en,
  input  logic [data_width-1:0] wr_data,
  input  logic                  wr_last,
  output logic                  m_axis_tvalid,
  input  logic                  m_axis_tready,
  output logic [data_width-1:0] m_axis_tdata,
  output logic                  m_axis_tlast,
  output logic                  burst_retired
);

  localparam int ptr_width = $clog2(depth);

  // Entry is {last, data}
  logic [data_width:0]  mem [depth];
  logic [ptr_width-1:0] wr_ptr;
  logic [ptr_width-1:0] rd_ptr;
  logic [ptr_width:0]   ram_count;
  logic                 head_free;
  logic                 ram_empty;
  logic                 ram_wr;
  logic                 ram_rd;

  // Head register can take a new entry this cycle
  assign head_free = !m_axis_tvalid || m_axis_tready;
  assign ram_empty = (ram_count == '0);
  assign ram_rd    = head_free && !ram_empty;
  // Bypass straight into the head when nothing is queued ahead
  assign ram_wr    = wr_en && !(head_free && ram_empty);

  assign burst_retired = m_axis_tvalid && m_axis_tready && m_axis_tlast;

  //////////////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (ram_wr) begin
      mem[wr_ptr] <= {wr_last, wr_data};
    end
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      ram_count <= '0;
    end else begin
      if (ram_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (ram_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({ram_wr, ram_rd})
        2'b10:   ram_count <= ram_count + 1'b1;
        2'b01:   ram_count <= ram_count - 1'b1;
        default: ram_count <= ram_count;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Registered head entry
  //////////////////////////////////////////////////////////////////////

  // Older queued data always goes first
  always_ff @(posedge aclk) begin
    if (head_free) begin
      if (!ram_empty) begin
        {m_axis_tlast, m_axis_tdata} <= mem[rd_ptr];
      end else if (wr_en) begin
        {m_axis_tlast, m_axis_tdata} <= {wr_last, wr_data};
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      m_axis_tvalid <= 1'b0;
    end else if (head_free) begin
      m_axis_tvalid <= !ram_empty || wr_en;
    end
  end

endmodule : read_data_fifo

`default_nettype wire

// File: verilog/r_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module r_tracker #(
  parameter int cnt_width = 54
) (
  input  logic          aclk,
  input  logic          areset,
  burst_plan_if.tracker plan,
  input  logic          m_axi_rvalid,
  input  logic          m_axi_rlast,
  output logic          ctrl_done
);

  logic last_beat;
  logic r_final;

  // rready is tied high, every valid beat is taken
  assign last_beat = m_axi_rvalid && m_axi_rlast;

  // R bursts still to finish
  burst_counter #(
    .width      (cnt_width),
    .init_value ('0)
  ) i_r_burst_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (plan.start),
    .incr       (1'b0),
    .decr       (last_beat),
    .load_value (plan.num_bursts),
    .count      (),
    .is_zero    (r_final)
  );

  // Counter wraps past zero on that beat, so the pulse lasts one cycle
  always_ff @(posedge aclk) begin
    if (areset) begin
      ctrl_done <= 1'b0;
    end else begin
      ctrl_done <= last_beat && r_final;
    end
  end

endmodule : r_tracker

`default_nettype wire

// File: verilog/ar_issuer.sv
`timescale 1ns/1ps
`default_nettype none

module ar_issuer #(
  parameter int addr_width      = read_master_pkg::DEFAULT_ADDR_WIDTH,
  parameter int data_width      = read_master_pkg::DEFAULT_DATA_WIDTH,
  parameter int cnt_width       = 54,
  parameter int max_outstanding = read_master_pkg::DEFAULT_MAX_OUTSTANDING
) (
  input  logic                  aclk,
  input  logic                  areset,
  burst_plan_if.issuer          plan,
  input  logic                  burst_retired,
  output logic                  m_axi_arvalid,
  input  logic                  m_axi_arready,
  output logic [addr_width-1:0] m_axi_araddr,
  output axi_pkg::axi_len_t     m_axi_arlen
);
  import axi_pkg::*;
  import read_master_pkg::*;

  localparam int       burst_len   = burst_beats(data_width);
  localparam int       burst_bytes = burst_len * data_width / 8;
  localparam int       vac_width   = $clog2(max_outstanding + 1);
  localparam axi_len_t full_len    = axi_len_t'(burst_len - 1);

  logic                 ar_idle;
  logic                 arxfer;
  logic                 ar_final;
  logic                 ar_done;
  logic                 stall_ar;
  // Bursts the stream side has room for
  logic [vac_width-1:0] vacancy_count;

  assign arxfer  = m_axi_arvalid && m_axi_arready;
  assign ar_done = arxfer && ar_final;

  // Only the last burst may be short
  assign m_axi_arlen = ar_final ? plan.final_len : full_len;

  //////////////////////////////////////////////////////////////////////
  // Request control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (areset) begin
      ar_idle <= 1'b1;
    end else if (plan.start) begin
      ar_idle <= 1'b0;
    end else if (ar_done) begin
      ar_idle <= 1'b1;
    end
  end

  // Held until accepted, one idle cycle between requests
  always_ff @(posedge aclk) begin
    if (areset) begin
      m_axi_arvalid <= 1'b0;
    end else if (!ar_idle && !stall_ar && !m_axi_arvalid) begin
      m_axi_arvalid <= 1'b1;
    end else if (m_axi_arready) begin
      m_axi_arvalid <= 1'b0;
    end
  end

  // Next burst starts one full burst further on
  always_ff @(posedge aclk) begin
    if (plan.start) begin
      m_axi_araddr <= plan.base_addr;
    end else if (arxfer) begin
      m_axi_araddr <= m_axi_araddr + addr_width'(burst_bytes);
    end
  end

  // Bursts still to request, zero flags the last one
  burst_counter #(
    .width      (cnt_width),
    .init_value ('0)
  ) i_ar_burst_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (plan.start),
    .incr       (1'b0),
    .decr       (arxfer),
    .load_value (plan.num_bursts),
    .count      (),
    .is_zero    (ar_final)
  );

  // Taken per request, given back as the stream drains a burst
  burst_counter #(
    .width      (vac_width),
    .init_value (vac_width'(max_outstanding))
  ) i_vacancy_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (1'b0),
    .incr       (burst_retired),
    .decr       (arxfer),
    .load_value ('0),
    .count      (vacancy_count),
    .is_zero    (stall_ar)
  );

endmodule : ar_issuer

`default_nettype wire

// File: verilog/xfer_setup.sv
`timescale 1ns/1ps
`default_nettype none

module xfer_setup #(
  parameter int addr_width      = read_master_pkg::DEFAULT_ADDR_WIDTH,
  parameter int data_width      = read_master_pkg::DEFAULT_DATA_WIDTH,
  parameter int xfer_size_width = addr_width,
  parameter int cnt_width       = 54
) (
  input  logic                       aclk,
  input  logic                       areset,
  input  logic                       ctrl_start,
  input  logic [addr_width-1:0]      ctrl_addr_offset,
  input  logic [xfer_size_width-1:0] ctrl_xfer_size_in_bytes,
  burst_plan_if.setup                plan
);
  import axi_pkg::*;
  import read_master_pkg::*;

  localparam int dw_bytes        = data_width / 8;
  localparam int log_dw_bytes    = $clog2(dw_bytes);
  localparam int burst_len       = burst_beats(data_width);
  localparam int log_burst_len   = $clog2(burst_len);
  localparam int total_len_width = xfer_size_width - log_dw_bytes;
  // Low address bits inside one full burst
  localparam logic [addr_width-1:0] addr_mask = addr_width'(dw_bytes * burst_len - 1);

  // Whole transfer in beats, minus one
  logic [total_len_width-1:0] total_len_r;
  logic                       start_d1;

  //////////////////////////////////////////////////////////////////////
  // Capture on ctrl_start
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (ctrl_start) begin
      // Partial beat rounds up, so the minus one cancels
      if (ctrl_xfer_size_in_bytes[log_dw_bytes-1:0] != '0) begin
        total_len_r <= ctrl_xfer_size_in_bytes[log_dw_bytes +: total_len_width];
      end else begin
        total_len_r <= ctrl_xfer_size_in_bytes[log_dw_bytes +: total_len_width] - 1'b1;
      end
      plan.base_addr <= ctrl_addr_offset & ~addr_mask;
    end
  end

  // Two-stage start delay, the split below settles in between
  always_ff @(posedge aclk) begin
    if (areset) begin
      start_d1   <= 1'b0;
      plan.start <= 1'b0;
    end else begin
      start_d1   <= ctrl_start;
      plan.start <= start_d1;
    end
  end

  // Upper beat bits count bursts, lower bits give the last ARLEN
  assign plan.num_bursts = total_len_r[log_burst_len +: cnt_width];

  always_ff @(posedge aclk) begin
    plan.final_len <= axi_len_t'(total_len_r[log_burst_len-1:0]);
  end

endmodule : xfer_setup

`default_nettype wire

// File: verilog/burst_counter.sv
`timescale 1ns/1ps
`default_nettype none

module burst_counter #(
  parameter int               width      = 8,
  parameter logic [width-1:0] init_value = '0
) (
  input  logic             aclk,
  input  logic             areset,
  input  logic             load,
  input  logic             incr,
  input  logic             decr,
  input  logic [width-1:0] load_value,
  output logic [width-1:0] count,
  output logic             is_zero
);

  logic [width-1:0] count_next;

  // Load wins, opposite steps in one cycle cancel
  always_comb begin
    count_next = count;
    if (load) begin
      count_next = load_value;
    end else if (incr && !decr) begin
      count_next = count + 1'b1;
    end else if (decr && !incr) begin
      count_next = count - 1'b1;
    end
  end

  // Zero flag registered together with the count
  always_ff @(posedge aclk) begin
    if (areset) begin
      count   <= init_value;
      is_zero <= (init_value == '0);
    end else begin
      count   <= count_next;
      is_zero <= (count_next == '0);
    end
  end

endmodule : burst_counter

`default_nettype wire

// File: verilog/burst_plan_if.sv
`timescale 1ns/1ps
`default_nettype none

interface burst_plan_if #(
  parameter int addr_width = read_master_pkg::DEFAULT_ADDR_WIDTH,
  // 64-bit size, 32-bit data: 64 - 2 - 8
  parameter int cnt_width  = 54
);
  import axi_pkg::*;

  // One-cycle pulse, plan below is valid from here on
  logic                  start;
  // Start address aligned down to a burst boundary
  logic [addr_width-1:0] base_addr;
  // Bursts in the transfer, minus one
  logic [cnt_width-1:0]  num_bursts;
  // ARLEN of the last burst
  axi_len_t              final_len;

  modport setup   (output start, output base_addr, output num_bursts, output final_len);
  modport issuer  (input start, input base_addr, input num_bursts, input final_len);
  modport tracker (input start, input num_bursts);

endinterface : burst_plan_if

`default_nettype wire

// File: verilog/read_master_pkg.sv
`default_nettype none

//////////////////////////////////////////////////////////////////////
// Read master configuration
//////////////////////////////////////////////////////////////////////

package read_master_pkg;

  // Top level parameter defaults
  localparam int DEFAULT_ADDR_WIDTH      = 64;
  localparam int DEFAULT_DATA_WIDTH      = 32;
  localparam int DEFAULT_MAX_OUTSTANDING = 16;

  // Beats in one full burst for a given bus width
  // Bounded by the 4 KiB rule and by the protocol length limit
  function automatic int burst_beats(input int data_width);
    int beats_by_bytes;
    beats_by_bytes = axi_pkg::AXI_MAX_BURST_BYTES / (data_width / 8);
    if (beats_by_bytes < axi_pkg::AXI_MAX_BURST_LEN) begin
      return beats_by_bytes;
    end
    return axi_pkg::AXI_MAX_BURST_LEN;
  endfunction

endpackage : read_master_pkg

`default_nettype wire

// File: verilog/axi_pkg.sv
`default_nettype none

//////////////////////////////////////////////////////////////////////
// AXI4 protocol limits
//////////////////////////////////////////////////////////////////////

package axi_pkg;

  // Longest INCR burst the protocol allows, in beats
  localparam int AXI_MAX_BURST_LEN = 256;

  // A burst may not cross a 4 KiB address boundary
  localparam int AXI_MAX_BURST_BYTES = 4096;

  // ARLEN encoding, beats minus one
  typedef logic [7:0] axi_len_t;

endpackage : axi_pkg

`default_nettype wire
